//--- verilog.f
+incdir+src
src/gnss_pkg.sv
src/code_ram.sv
src/code_phase_gen.sv
src/ctrl_word_ram.sv
src/ctrl_update_seq.sv
src/gnss_channel.sv
src/gnss_baseband_top.sv
dv/tb_gnss_baseband.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents.
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_gnss_baseband \
    -o sim_gnss \
    && ./obj_dir/sim_gnss > sim.log 2>&1 \
    ; cat sim.log \
    && grep -q "^TEST OK$" sim.log \
    || { echo "simulation did not pass"; exit 1; }

//--- dv/tb_gnss_baseband.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module tb_gnss_baseband
    import gnss_pkg::*;
;

    localparam int CH_W           = $clog2(`GNSS_CHANNELS);
    localparam int UPD            = `GNSS_UPDATE_DIV;
    localparam int TIMEOUT_CYCLES = 3 * UPD + 3000;  // three update periods plus chip checks.

    typedef struct packed {
        logic [31:0] carrier;
        logic [31:0] code_freq;
        logic [31:0] phase;
        logic [9:0]  delay;
        logic [31:0] code_seed;
    } row_t;

    logic                              clk;
    logic                              rst_n;
    logic [`GNSS_WORD_W-1:0]           wr_data;
    wr_en_t                            wr_en;
    logic [`GNSS_CHANNELS-1:0]         code_tick;
    chan_params_t [`GNSS_CHANNELS-1:0] params;
    logic [`GNSS_CHANNELS-1:0]         code_bit;

    row_t        rows [2][`GNSS_CHANNELS];             // pass 0 and pass 1 contents.
    logic [31:0] code_mem [`GNSS_CHANNELS][`GNSS_CODE_WORDS];
    int          chip_cnt [`GNSS_CHANNELS];
    int          seed;
    int          cyc;
    int          wd_cnt;
    int          n_checks;
    int          n_errors;

    gnss_baseband_top gnss_baseband_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .code_tick (code_tick),
        .params    (params),
        .code_bit  (code_bit)
    );

    always #5 clk = ~clk;

    // cycles since reset release, lines up with the update divider.
    always @(posedge clk) begin
        if (rst_n) begin
            cyc <= cyc + 1;
        end
        wd_cnt <= wd_cnt + 1;
    end

    initial begin
        wait (wd_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic fill_table();
        rows[0][0] = '{32'h1a2b3c4d, 32'd2746100, 32'd17,   10'd0,    32'h5a5a0f0f};
        rows[0][1] = '{32'h00c0ffee, 32'd2745000, 32'd900,  10'd5,    32'h13572468};
        rows[0][2] = '{32'h7fff0001, 32'd1023000, 32'd3,    10'd512,  32'hdeadbeef};
        rows[0][3] = '{32'h80000000, 32'd2046000, 32'd1022, 10'd1022, 32'h0};
        rows[1][0] = '{32'h2b3c4d5e, 32'd2746200, 32'd18,   10'd700,  32'ha5a5f0f0};
        rows[1][1] = '{32'h01c0ffee, 32'd2745100, 32'd901,  10'd1022, 32'h24681357};
        rows[1][2] = '{32'h6fff0002, 32'd1023100, 32'd4,    10'd0,    32'hbeefdead};
        rows[1][3] = '{32'h90000000, 32'd2046100, 32'd1021, 10'd31,   32'hffff0000};
    endtask

    function automatic logic [31:0] ctrl_word(row_t row, int k);
        case (k)
            0:       return row.carrier;
            1:       return row.code_freq;
            2:       return row.phase;
            default: return {22'd0, row.delay};  // delay sits in the low bits.
        endcase
    endfunction

    task automatic wait_cycle_count(int target);
        @(negedge clk);
        while (cyc < target) @(negedge clk);
    endtask

    task automatic compare_word(string what, int ch, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: ch%0d %s is %0d, expected %0d",
                     $time, ch, what, got, exp);
        end
    endtask

    task automatic write_ctrl(int ch, int pass);
        logic [CH_W-1:0] cidx;
        cidx = CH_W'(ch);
        for (int k = 0; k < `GNSS_CTRL_WORDS; k++) begin
            @(posedge clk);
            wr_en.ctrl_we[cidx] <= 1'b1;
            wr_data             <= ctrl_word(rows[pass][ch], k);
        end
        @(posedge clk);
        wr_en.ctrl_we[cidx] <= 1'b0;
    endtask

    task automatic write_code(int ch, int pass);
        logic [CH_W-1:0] cidx;
        logic [31:0]     word;
        cidx = CH_W'(ch);
        for (int w = 0; w < `GNSS_CODE_WORDS; w++) begin
            word = $random(seed) ^ rows[pass][ch].code_seed;
            code_mem[ch][w] = word;  // model copy of the code.
            @(posedge clk);
            wr_en.code_we[cidx] <= 1'b1;
            wr_data             <= word;
        end
        @(posedge clk);
        wr_en.code_we[cidx] <= 1'b0;
    endtask

    task automatic verify_reset();
        for (int ch = 0; ch < `GNSS_CHANNELS; ch++) begin
            compare_word("carrier", ch, params[ch].carrier_freq, 32'd0);
            compare_word("code_freq", ch, params[ch].code_freq, `GNSS_CODE_FREQ_RST);
            compare_word("code_phase", ch, params[ch].code_phase, 32'd0);
            compare_word("code_bit", ch, code_bit[ch], 32'd0);
        end
    endtask

    task automatic verify_params(int pass);
        for (int ch = 0; ch < `GNSS_CHANNELS; ch++) begin
            compare_word("carrier", ch, params[ch].carrier_freq, rows[pass][ch].carrier);
            compare_word("code_freq", ch, params[ch].code_freq, rows[pass][ch].code_freq);
            compare_word("code_phase", ch, params[ch].code_phase, rows[pass][ch].phase);
        end
    endtask

    // chip at the delayed address, wrapping into the previous period.
    function automatic logic expected_chip(int ch, int cnt, int dly);
        int addr;
        if (cnt > dly) begin
            addr = cnt - dly;
        end else begin
            addr = `GNSS_CODE_LEN - dly + cnt;
        end
        return code_mem[ch][addr / 32][addr % 32];
    endfunction

    // one tick on all channels every third cycle.
    task automatic run_chips(int n_ticks, int pass);
        int   dly;
        logic exp;
        for (int t = 0; t < n_ticks; t++) begin
            @(posedge clk);
            code_tick <= '1;
            @(posedge clk);
            code_tick <= '0;
            @(posedge clk);
            @(negedge clk);  // two cycles after the tick.
            for (int ch = 0; ch < `GNSS_CHANNELS; ch++) begin
                if (chip_cnt[ch] == `GNSS_CODE_LEN) begin
                    chip_cnt[ch] = 1;
                end else begin
                    chip_cnt[ch] = chip_cnt[ch] + 1;
                end
                dly = rows[pass][ch].delay;
                exp = expected_chip(ch, chip_cnt[ch], dly);
                compare_word("code_bit", ch, code_bit[ch], exp);
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_data   = '0;
        wr_en     = '0;
        code_tick = '0;
        seed      = 32'hafa28e80;
        fill_table();
        for (int ch = 0; ch < `GNSS_CHANNELS; ch++) begin
            chip_cnt[ch] = 1;
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        verify_reset();

        // first load, taken by the first update tick.
        for (int ch = 0; ch < `GNSS_CHANNELS; ch++) begin
            write_ctrl(ch, 0);
            write_code(ch, 0);
        end
        wait_cycle_count(UPD + 6);
        verify_params(0);
        run_chips(1100, 0);  // enough ticks for the counter to wrap.

        // second load, channel 0 code burst straddles the second tick.
        for (int ch = 0; ch < `GNSS_CHANNELS; ch++) begin
            write_ctrl(ch, 1);
        end
        for (int ch = 1; ch < `GNSS_CHANNELS; ch++) begin
            write_code(ch, 1);
        end
        wait_cycle_count(2 * UPD - 16);
        write_code(0, 1);
        wait_cycle_count(2 * UPD + 6);
        verify_params(0);
        wait_cycle_count(3 * UPD + 6);
        verify_params(1);
        run_chips(300, 1);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/gnss_baseband_top.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module gnss_baseband_top
    import gnss_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [`GNSS_WORD_W-1:0]             wr_data,
    input  wr_en_t                              wr_en,
    input  logic [`GNSS_CHANNELS-1:0]           code_tick,
    output chan_params_t [`GNSS_CHANNELS-1:0]   params,
    output logic [`GNSS_CHANNELS-1:0]           code_bit
);

    ctrl_sel_e                   rd_idx;
    logic [`GNSS_CTRL_WORDS-1:0] load_sel;
    logic                        busy;

    // any write on any channel holds off the update.
    assign busy = |wr_en;

    ctrl_update_seq ctrl_update_seq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .busy     (busy),
        .rd_idx   (rd_idx),
        .load_sel (load_sel)
    );

    for (genvar ch = 0; ch < `GNSS_CHANNELS; ch++) begin : g_chan
        gnss_channel gnss_channel_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_data   (wr_data),
            .code_we   (wr_en.code_we[ch]),
            .ctrl_we   (wr_en.ctrl_we[ch]),
            .code_tick (code_tick[ch]),
            .rd_idx    (rd_idx),
            .load_sel  (load_sel),
            .params    (params[ch]),
            .code_bit  (code_bit[ch])
        );
    end

endmodule

//--- src/gnss_channel.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module gnss_channel
    import gnss_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`GNSS_WORD_W-1:0]     wr_data,
    input  logic                        code_we,
    input  logic                        ctrl_we,
    input  logic                        code_tick,
    input  ctrl_sel_e                   rd_idx,
    input  logic [`GNSS_CTRL_WORDS-1:0] load_sel,
    output chan_params_t                params,
    output logic                        code_bit
);

    ctrl_word_u                   rd_word;
    logic [`GNSS_CODE_ADDR_W-1:0] code_delay;
    logic [`GNSS_CODE_ADDR_W-1:0] code_addr;

    ctrl_word_ram ctrl_word_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (ctrl_we),
        .wr_data (wr_data),
        .rd_idx  (rd_idx),
        .rd_word (rd_word)
    );

    // live registers, each taken on its own load strobe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            params.carrier_freq <= `GNSS_CARRIER_RST;
            params.code_freq    <= `GNSS_CODE_FREQ_RST;
            params.code_phase   <= `GNSS_CODE_PHASE_RST;
            code_delay          <= `GNSS_CODE_DELAY_RST;
        end else begin
            if (load_sel[CTRL_CARRIER]) begin
                params.carrier_freq <= rd_word.raw;
            end
            if (load_sel[CTRL_CODE_FREQ]) begin
                params.code_freq <= rd_word.raw;
            end
            if (load_sel[CTRL_CODE_PHASE]) begin
                params.code_phase <= rd_word.raw;
            end
            if (load_sel[CTRL_DELAY]) begin
                code_delay <= rd_word.delay.code_delay;  // only the low 10 bits matter.
            end
        end
    end

    code_phase_gen code_phase_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_tick  (code_tick),
        .code_delay (code_delay),
        .rd_addr    (code_addr)
    );

    code_ram code_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (code_we),
        .wr_data (wr_data),
        .rd_addr (code_addr),
        .chip    (code_bit)
    );

endmodule

//--- src/ctrl_update_seq.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module ctrl_update_seq
    import gnss_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        busy,
    output ctrl_sel_e                   rd_idx,
    output logic [`GNSS_CTRL_WORDS-1:0] load_sel
);

    localparam int DIV_W = $clog2(`GNSS_UPDATE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             upd_tick;
    logic             seq_active;
    logic [1:0]       seq_step;

    assign upd_tick = (div_cnt == DIV_W'(`GNSS_UPDATE_DIV - 1));

    // free running divider, tick on its last count.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (upd_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // four reads back to back, load strobe trails each read by one cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_active <= 1'b0;
            seq_step   <= 2'd0;
            load_sel   <= '0;
        end else begin
            load_sel <= seq_active ? (`GNSS_CTRL_WORDS'(1) << seq_step) : '0;
            if (seq_active) begin
                seq_step <= seq_step + 2'd1;     // wraps to 0 after the delay word.
                if (seq_step == 2'd3) begin
                    seq_active <= 1'b0;
                end
            end else if (upd_tick && !busy) begin
                seq_active <= 1'b1;              // update skipped while writing.
            end
        end
    end

    assign rd_idx = ctrl_sel_e'(seq_step);

    // the carrier load comes two cycles after a tick that saw no write.
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        load_sel[CTRL_CARRIER] |-> $past(upd_tick && !busy, 2));

endmodule

//--- src/ctrl_word_ram.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module ctrl_word_ram
    import gnss_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we,
    input  logic [`GNSS_WORD_W-1:0] wr_data,
    input  ctrl_sel_e               rd_idx,
    output ctrl_word_u              rd_word
);

    logic [`GNSS_WORD_W-1:0] mem [`GNSS_CTRL_WORDS];
    ctrl_sel_e               wr_idx;

    // write index wraps 3 to 0 and restarts after each burst.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= CTRL_CARRIER;
        end else if (we) begin
            wr_idx <= ctrl_sel_e'(wr_idx + 2'd1);
        end else begin
            wr_idx <= CTRL_CARRIER;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // synchronous read, one cycle behind rd_idx.
    always_ff @(posedge clk) begin
        rd_word.raw <= mem[rd_idx];
    end

endmodule

//--- src/code_phase_gen.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module code_phase_gen (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         code_tick,
    input  logic [`GNSS_CODE_ADDR_W-1:0] code_delay,
    output logic [`GNSS_CODE_ADDR_W-1:0] rd_addr
);

    localparam logic [`GNSS_CODE_ADDR_W-1:0] CODE_LAST = `GNSS_CODE_ADDR_W'(`GNSS_CODE_LEN);
    localparam logic [`GNSS_CODE_ADDR_W-1:0] CODE_FIRST = `GNSS_CODE_ADDR_W'(1);

    logic [`GNSS_CODE_ADDR_W-1:0] chip_cnt;

    // chip counter runs 1..1023, one step per code tick.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chip_cnt <= CODE_FIRST;
        end else if (code_tick) begin
            if (chip_cnt == CODE_LAST) begin
                chip_cnt <= CODE_FIRST;
            end else begin
                chip_cnt <= chip_cnt + 1'b1;
            end
        end
    end

    // delayed chip, wrapping back into the previous code period.
    always_comb begin
        if (chip_cnt > code_delay) begin
            rd_addr = chip_cnt - code_delay;
        end else begin
            rd_addr = CODE_LAST - code_delay + chip_cnt;
        end
    end

    // address 0 is not a chip, the counter must never land there.
    a_chip_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        code_tick |=> (chip_cnt != '0));

endmodule

//--- src/code_ram.sv
`timescale 1ns/1ps
`include "gnss_settings.svh"

module code_ram (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         we,
    input  logic [`GNSS_WORD_W-1:0]      wr_data,
    input  logic [`GNSS_CODE_ADDR_W-1:0] rd_addr,
    output logic                         chip
);

    localparam int BIT_W  = $clog2(`GNSS_WORD_W);
    localparam int WIDX_W = $clog2(`GNSS_CODE_WORDS);

    logic [`GNSS_WORD_W-1:0] mem [`GNSS_CODE_WORDS];
    logic [WIDX_W-1:0]       wr_idx;

    // word index runs while we is held, restarts once it drops.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
        end else if (we) begin
            wr_idx <= wr_idx + 1'b1;
        end else begin
            wr_idx <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // upper address bits pick the word, lower bits the chip.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chip <= 1'b0;
        end else begin
            chip <= mem[rd_addr[`GNSS_CODE_ADDR_W-1:BIT_W]][rd_addr[BIT_W-1:0]];
        end
    end

    // a load is one full code, the last word must end the burst.
    a_code_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        (we && wr_idx == WIDX_W'(`GNSS_CODE_WORDS - 1)) |=> !we);

endmodule

//--- src/gnss_pkg.sv
`include "gnss_settings.svh"

package gnss_pkg;

    // live parameters of one channel, as seen at the top ports.
    typedef struct packed {
        logic [`GNSS_WORD_W-1:0] carrier_freq;
        logic [`GNSS_WORD_W-1:0] code_freq;
        logic [`GNSS_WORD_W-1:0] code_phase;
    } chan_params_t;

    // one enable bit per channel for each store.
    typedef struct packed {
        logic [`GNSS_CHANNELS-1:0] code_we;
        logic [`GNSS_CHANNELS-1:0] ctrl_we;
    } wr_en_t;

    // control word, either taken whole or as the code delay field.
    typedef union packed {
        logic [`GNSS_WORD_W-1:0] raw;
        struct packed {
            logic [`GNSS_WORD_W-`GNSS_CODE_ADDR_W-1:0] unused;
            logic [`GNSS_CODE_ADDR_W-1:0]              code_delay;
        } delay;
    } ctrl_word_u;

    // control word order inside each channel's store.
    typedef enum logic [1:0] {
        CTRL_CARRIER    = 2'd0,
        CTRL_CODE_FREQ  = 2'd1,
        CTRL_CODE_PHASE = 2'd2,
        CTRL_DELAY      = 2'd3
    } ctrl_sel_e;

endpackage

//--- src/gnss_settings.svh
`ifndef GNSS_SETTINGS_SVH
`define GNSS_SETTINGS_SVH

// channel count and data path widths.
`define GNSS_CHANNELS       4
`define GNSS_WORD_W         32

// spreading code geometry.
`define GNSS_CODE_LEN       1023   // chips per code period.
`define GNSS_CODE_ADDR_W    10
`define GNSS_CODE_WORDS     32     // 32 x 32 bits covers 1023 chips.

// control store and update rate.
`define GNSS_CTRL_WORDS     4
`define GNSS_UPDATE_DIV     10000  // clk cycles per parameter update.

// reset values of the live registers.
`define GNSS_CARRIER_RST    32'd0
`define GNSS_CODE_FREQ_RST  32'd2746095
`define GNSS_CODE_PHASE_RST 32'd0
`define GNSS_CODE_DELAY_RST 10'd0

`endif
